//--- hw/csr_pkg.sv
package csr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] u32_t;      // Data word.
    typedef logic [13:0] csr_addr_t; // CSR number.
    typedef logic [1:0]  plv_t;      // Privilege level.
    typedef logic [5:0]  ecode_t;    // Exception code.

    typedef struct packed {
        logic   we;      // Exception write strobe.
        plv_t   plv;     // New crmd.plv.
        logic   ie;      // New crmd.ie.
        plv_t   pplv;    // Saved plv into prmd.
        logic   pie;     // Saved ie into prmd.
        ecode_t ecode;   // Goes to estat[21:16].
        u32_t   era;
        u32_t   badv;
        logic   badv_we;
    } excp_wr_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam csr_addr_t CSR_CRMD      = 14'h000;
    localparam csr_addr_t CSR_PRMD      = 14'h001;
    localparam csr_addr_t CSR_EUEN      = 14'h002;
    localparam csr_addr_t CSR_ECFG      = 14'h004;
    localparam csr_addr_t CSR_ESTAT     = 14'h005;
    localparam csr_addr_t CSR_ERA       = 14'h006;
    localparam csr_addr_t CSR_BADV      = 14'h007;
    localparam csr_addr_t CSR_EENTRY    = 14'h00c;
    localparam csr_addr_t CSR_TLBIDX    = 14'h010;
    localparam csr_addr_t CSR_TLBEHI    = 14'h011;
    localparam csr_addr_t CSR_TLBELO0   = 14'h012;
    localparam csr_addr_t CSR_TLBELO1   = 14'h013;
    localparam csr_addr_t CSR_ASID      = 14'h018;
    localparam csr_addr_t CSR_PGDL      = 14'h019;
    localparam csr_addr_t CSR_PGDH      = 14'h01a;
    localparam csr_addr_t CSR_PGD       = 14'h01b;
    localparam csr_addr_t CSR_CPUID     = 14'h020;
    localparam csr_addr_t CSR_SAVE0     = 14'h030;
    localparam csr_addr_t CSR_SAVE1     = 14'h031;
    localparam csr_addr_t CSR_SAVE2     = 14'h032;
    localparam csr_addr_t CSR_SAVE3     = 14'h033;
    localparam csr_addr_t CSR_TLBRENTRY = 14'h088;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writable bits per CSR
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam u32_t MASK_CRMD      = 32'h0000_01ff; // plv, ie, da, pg, datf, datm.
    localparam u32_t MASK_PRMD      = 32'h0000_0007;
    localparam u32_t MASK_EUEN      = 32'h0000_0001;
    localparam u32_t MASK_ECFG      = 32'h0000_1bff; // Bit 10 is reserved.
    localparam u32_t MASK_ESTAT     = 32'h0000_0003; // Software interrupts only.
    localparam u32_t MASK_ERA       = 32'hffff_ffff;
    localparam u32_t MASK_BADV      = 32'hffff_ffff;
    localparam u32_t MASK_EENTRY    = 32'hffff_ffc0;
    localparam u32_t MASK_TLBIDX    = 32'hbf00_000f; // ne, ps, 4-bit index.
    localparam u32_t MASK_TLBEHI    = 32'hffff_e000;
    localparam u32_t MASK_TLBELO    = 32'h0fff_ff7f;
    localparam u32_t MASK_ASID      = 32'h0000_03ff;
    localparam u32_t MASK_PGD_BASE  = 32'hffff_f000;
    localparam u32_t MASK_SAVE      = 32'hffff_ffff;
    localparam u32_t MASK_TLBRENTRY = 32'hffff_ffc0;

    localparam u32_t       CRMD_RESET = 32'h0000_0008; // Direct address mode.
    localparam logic [7:0] ASID_BITS  = 8'd10;

    // Queue and credit sizing.
    localparam int CSR_REQ_DEPTH = 4;
    localparam int RESP_CREDITS  = 2;
    localparam int PTR_W         = 2;
    localparam int CRED_W        = 2;

endpackage

//--- hw/csr_issue_if.sv
`timescale 1ns/10ps

interface csr_issue_if;
    import csr_pkg::*;

    logic      issue;          // One access goes through this cycle.
    csr_addr_t addr;
    logic      we;
    u32_t      wr_data;
    logic      ready;          // Register file can take an access.
    u32_t      rd_data;        // Old value of the addressed CSR.
    logic      resp_credit_ok; // Egress holds a downstream credit.

    modport ingress (output issue, output addr, output we, output wr_data,
                     input ready, input resp_credit_ok);

    modport regfile (input issue, input addr, input we, input wr_data,
                     output ready, output rd_data);

    modport egress (input issue, input rd_data, output resp_credit_ok);

endinterface

//--- hw/csr_req_ingress.sv
`timescale 1ns/10ps

module csr_req_ingress (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  csr_pkg::csr_addr_t req_addr,
    input  logic               req_we,
    input  csr_pkg::u32_t      req_wdata,
    output logic               req_credit,
    csr_issue_if.ingress       issue_if
);
    import csr_pkg::*;

    csr_addr_t        addr_mem [CSR_REQ_DEPTH];
    logic             we_mem   [CSR_REQ_DEPTH];
    u32_t             data_mem [CSR_REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // Needs one bit more than the pointers.
    logic             pop;

    // The only place where the issue handshake is decided.
    assign pop = (count != '0) && issue_if.ready && issue_if.resp_credit_ok;

    assign issue_if.issue   = pop;
    assign issue_if.addr    = addr_mem[rd_ptr]; // Head of queue.
    assign issue_if.we      = we_mem[rd_ptr];
    assign issue_if.wr_data = data_mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (req_valid) begin           // Requester credit keeps this from overflowing.
            addr_mem[wr_ptr] <= req_addr;
            we_mem[wr_ptr]   <= req_we;
            data_mem[wr_ptr] <= req_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and credit return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr + PTR_W'(req_valid);   // Wraps at depth four.
            rd_ptr     <= rd_ptr + PTR_W'(pop);
            count      <= count + (PTR_W + 1)'(req_valid) - (PTR_W + 1)'(pop);
            req_credit <= pop;                        // One credit per freed slot.
        end
    end

endmodule

//--- hw/csr_regfile.sv
`timescale 1ns/10ps

module csr_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    csr_issue_if.regfile          issue_if,
    input  csr_pkg::excp_wr_req_t excp_req,
    input  logic                  event_busy,
    output csr_pkg::plv_t         crmd_plv,
    output logic                  crmd_ie,
    output csr_pkg::plv_t         prmd_pplv,
    output logic                  prmd_pie,
    output csr_pkg::u32_t         era,
    output csr_pkg::u32_t         eentry
);
    import csr_pkg::*;

    u32_t crmd, prmd, euen, ecfg, estat, badv;
    u32_t tlbidx, tlbehi, tlbelo0, tlbelo1, asid, pgdl, pgdh;
    u32_t save0, save1, save2, save3, tlbrentry;
    u32_t pgd;
    logic inst_we;

    // Keeps the unmasked bits of the old value.
    function automatic u32_t merge(u32_t old_val, u32_t new_val, u32_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // Trap and ertn own the cycle they occur in.
    assign issue_if.ready = ~event_busy;
    assign inst_we        = issue_if.issue && issue_if.we;

    assign crmd_plv  = crmd[1:0];
    assign crmd_ie   = crmd[2];
    assign prmd_pplv = prmd[1:0];
    assign prmd_pie  = prmd[2];

    // Page directory base follows the address half in badv.
    assign pgd = badv[31] ? (pgdh & MASK_PGD_BASE) : (pgdl & MASK_PGD_BASE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (issue_if.addr)
            CSR_CRMD:      issue_if.rd_data = crmd;
            CSR_PRMD:      issue_if.rd_data = prmd;
            CSR_EUEN:      issue_if.rd_data = euen;
            CSR_ECFG:      issue_if.rd_data = ecfg;
            CSR_ESTAT:     issue_if.rd_data = estat;
            CSR_ERA:       issue_if.rd_data = era;
            CSR_BADV:      issue_if.rd_data = badv;
            CSR_EENTRY:    issue_if.rd_data = eentry;
            CSR_TLBIDX:    issue_if.rd_data = tlbidx;
            CSR_TLBEHI:    issue_if.rd_data = tlbehi;
            CSR_TLBELO0:   issue_if.rd_data = tlbelo0;
            CSR_TLBELO1:   issue_if.rd_data = tlbelo1;
            CSR_ASID:      issue_if.rd_data = {asid[31:24], ASID_BITS, asid[15:0]};
            CSR_PGDL:      issue_if.rd_data = pgdl;
            CSR_PGDH:      issue_if.rd_data = pgdh;
            CSR_PGD:       issue_if.rd_data = pgd;
            CSR_CPUID:     issue_if.rd_data = '0;   // Single core.
            CSR_SAVE0:     issue_if.rd_data = save0;
            CSR_SAVE1:     issue_if.rd_data = save1;
            CSR_SAVE2:     issue_if.rd_data = save2;
            CSR_SAVE3:     issue_if.rd_data = save3;
            CSR_TLBRENTRY: issue_if.rd_data = tlbrentry;
            default:       issue_if.rd_data = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd      <= CRMD_RESET;
            {prmd, euen, ecfg, estat, era, badv, eentry} <= '0;
            {tlbidx, tlbehi, tlbelo0, tlbelo1, asid, pgdl, pgdh} <= '0;
            {save0, save1, save2, save3, tlbrentry} <= '0;
        end else if (excp_req.we) begin
            crmd[2:0]    <= {excp_req.ie, excp_req.plv};
            prmd[2:0]    <= {excp_req.pie, excp_req.pplv};
            estat[21:16] <= excp_req.ecode;
            era          <= excp_req.era;
            if (excp_req.badv_we) begin
                badv <= excp_req.badv;
            end
        end else if (inst_we) begin
            case (issue_if.addr)
                CSR_CRMD:      crmd      <= merge(crmd, issue_if.wr_data, MASK_CRMD);
                CSR_PRMD:      prmd      <= merge(prmd, issue_if.wr_data, MASK_PRMD);
                CSR_EUEN:      euen      <= merge(euen, issue_if.wr_data, MASK_EUEN);
                CSR_ECFG:      ecfg      <= merge(ecfg, issue_if.wr_data, MASK_ECFG);
                CSR_ESTAT:     estat     <= merge(estat, issue_if.wr_data, MASK_ESTAT);
                CSR_ERA:       era       <= merge(era, issue_if.wr_data, MASK_ERA);
                CSR_BADV:      badv      <= merge(badv, issue_if.wr_data, MASK_BADV);
                CSR_EENTRY:    eentry    <= merge(eentry, issue_if.wr_data, MASK_EENTRY);
                CSR_TLBIDX:    tlbidx    <= merge(tlbidx, issue_if.wr_data, MASK_TLBIDX);
                CSR_TLBEHI:    tlbehi    <= merge(tlbehi, issue_if.wr_data, MASK_TLBEHI);
                CSR_TLBELO0:   tlbelo0   <= merge(tlbelo0, issue_if.wr_data, MASK_TLBELO);
                CSR_TLBELO1:   tlbelo1   <= merge(tlbelo1, issue_if.wr_data, MASK_TLBELO);
                CSR_ASID:      asid      <= merge(asid, issue_if.wr_data, MASK_ASID);
                CSR_PGDL:      pgdl      <= merge(pgdl, issue_if.wr_data, MASK_PGD_BASE);
                CSR_PGDH:      pgdh      <= merge(pgdh, issue_if.wr_data, MASK_PGD_BASE);
                CSR_SAVE0:     save0     <= merge(save0, issue_if.wr_data, MASK_SAVE);
                CSR_SAVE1:     save1     <= merge(save1, issue_if.wr_data, MASK_SAVE);
                CSR_SAVE2:     save2     <= merge(save2, issue_if.wr_data, MASK_SAVE);
                CSR_SAVE3:     save3     <= merge(save3, issue_if.wr_data, MASK_SAVE);
                CSR_TLBRENTRY: tlbrentry <= merge(tlbrentry, issue_if.wr_data, MASK_TLBRENTRY);
                default:       ;         // pgd, cpuid and holes ignore writes.
            endcase
        end
    end

endmodule

//--- hw/csr_excp_seq.sv
`timescale 1ns/10ps

module csr_excp_seq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  trap,
    input  csr_pkg::ecode_t       trap_ecode,
    input  csr_pkg::u32_t         trap_pc,
    input  csr_pkg::u32_t         trap_badv,
    input  logic                  trap_badv_we,
    input  logic                  ertn,
    input  csr_pkg::plv_t         crmd_plv,
    input  logic                  crmd_ie,
    input  csr_pkg::plv_t         prmd_pplv,
    input  logic                  prmd_pie,
    input  csr_pkg::u32_t         era,
    input  csr_pkg::u32_t         eentry,
    output csr_pkg::excp_wr_req_t excp_req,
    output logic                  event_busy,
    output logic                  redirect_valid,
    output csr_pkg::u32_t         redirect_pc
);
    import csr_pkg::*;

    ecode_t last_ecode;   // Copy of estat[21:16], only traps write it.

    assign event_busy = trap | ertn;

    always_comb begin
        excp_req = '0;
        if (trap) begin                  // Trap wins over ertn.
            excp_req.we      = 1'b1;
            excp_req.plv     = 2'd0;     // Enter kernel with interrupts off.
            excp_req.ie      = 1'b0;
            excp_req.pplv    = crmd_plv;
            excp_req.pie     = crmd_ie;
            excp_req.ecode   = trap_ecode;
            excp_req.era     = trap_pc;
            excp_req.badv    = trap_badv;
            excp_req.badv_we = trap_badv_we;
        end else if (ertn) begin
            excp_req.we      = 1'b1;
            excp_req.plv     = prmd_pplv;
            excp_req.ie      = prmd_pie;
            excp_req.pplv    = prmd_pplv; // prmd stays as it is.
            excp_req.pie     = prmd_pie;
            excp_req.ecode   = last_ecode;
            excp_req.era     = era;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
            last_ecode     <= '0;
        end else begin
            redirect_valid <= event_busy;
            if (trap) begin
                last_ecode <= trap_ecode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (event_busy) begin
            redirect_pc <= trap ? eentry : era; // Values before this edge's update.
        end
    end

endmodule

//--- hw/csr_resp_egress.sv
`timescale 1ns/10ps

module csr_resp_egress (
    input  logic          clk,
    input  logic          rst_n,
    csr_issue_if.egress   issue_if,
    input  logic          resp_credit,
    output logic          resp_valid,
    output csr_pkg::u32_t resp_data
);
    import csr_pkg::*;

    logic [CRED_W-1:0] credits;

    assign issue_if.resp_credit_ok = (credits != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Downstream credit counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits    <= CRED_W'(RESP_CREDITS);
            resp_valid <= 1'b0;
        end else begin
            // The credit is taken at issue, so the next cycle sees the lower count.
            credits    <= credits - CRED_W'(issue_if.issue) + CRED_W'(resp_credit);
            resp_valid <= issue_if.issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_if.issue) begin
            resp_data <= issue_if.rd_data;  // Old value before the write.
        end
    end

endmodule

//--- hw/csr_unit_top.sv
`timescale 1ns/10ps

module csr_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  csr_pkg::csr_addr_t req_addr,
    input  logic               req_we,
    input  csr_pkg::u32_t      req_wdata,
    output logic               req_credit,
    output logic               resp_valid,
    output csr_pkg::u32_t      resp_data,
    input  logic               resp_credit,
    input  logic               trap,
    input  csr_pkg::ecode_t    trap_ecode,
    input  csr_pkg::u32_t      trap_pc,
    input  csr_pkg::u32_t      trap_badv,
    input  logic               trap_badv_we,
    input  logic               ertn,
    output logic               redirect_valid,
    output csr_pkg::u32_t      redirect_pc,
    output csr_pkg::plv_t      crmd_plv,
    output logic               crmd_ie
);
    import csr_pkg::*;

    excp_wr_req_t excp_req;
    logic         event_busy;
    plv_t         prmd_pplv;
    logic         prmd_pie;
    u32_t         era;
    u32_t         eentry;

    csr_issue_if issue_if ();

    csr_req_ingress i_csr_req_ingress (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_addr(req_addr),
        .req_we(req_we), .req_wdata(req_wdata), .req_credit(req_credit),
        .issue_if(issue_if.ingress)
    );

    csr_regfile i_csr_regfile (
        .clk(clk), .rst_n(rst_n), .issue_if(issue_if.regfile),
        .excp_req(excp_req), .event_busy(event_busy),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .prmd_pplv(prmd_pplv),
        .prmd_pie(prmd_pie), .era(era), .eentry(eentry)
    );

    csr_excp_seq i_csr_excp_seq (
        .clk(clk), .rst_n(rst_n), .trap(trap), .trap_ecode(trap_ecode),
        .trap_pc(trap_pc), .trap_badv(trap_badv), .trap_badv_we(trap_badv_we),
        .ertn(ertn), .crmd_plv(crmd_plv), .crmd_ie(crmd_ie),
        .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie), .era(era), .eentry(eentry),
        .excp_req(excp_req), .event_busy(event_busy),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    csr_resp_egress i_csr_resp_egress (
        .clk(clk), .rst_n(rst_n), .issue_if(issue_if.egress),
        .resp_credit(resp_credit), .resp_valid(resp_valid), .resp_data(resp_data)
    );

endmodule

//--- testbench/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference CSR state and credit tracking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
u32_t      m_csr [csr_addr_t];   // CSRs with storage behind them.
csr_addr_t csr_list [22] = '{
    CSR_CRMD, CSR_PRMD, CSR_EUEN, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
    CSR_TLBIDX, CSR_TLBEHI, CSR_TLBELO0, CSR_TLBELO1, CSR_ASID, CSR_PGDL, CSR_PGDH,
    CSR_PGD, CSR_CPUID, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TLBRENTRY
};
u32_t exp_q [$];   // Expected old value per request, in order.
int   req_cred;    // Requester credits held.
int   cons_cred;   // Downstream credits held by the egress.
int   owed;        // Responses not yet credited back.

function automatic u32_t write_mask(csr_addr_t a);
    case (a)
        CSR_CRMD:                 return MASK_CRMD;
        CSR_PRMD:                 return MASK_PRMD;
        CSR_EUEN:                 return MASK_EUEN;
        CSR_ECFG:                 return MASK_ECFG;
        CSR_ESTAT:                return MASK_ESTAT;
        CSR_ERA, CSR_BADV:        return 32'hffff_ffff;
        CSR_EENTRY:               return MASK_EENTRY;
        CSR_TLBIDX:               return MASK_TLBIDX;
        CSR_TLBEHI:               return MASK_TLBEHI;
        CSR_TLBELO0, CSR_TLBELO1: return MASK_TLBELO;
        CSR_ASID:                 return MASK_ASID;
        CSR_PGDL, CSR_PGDH:       return MASK_PGD_BASE;
        CSR_TLBRENTRY:            return MASK_TLBRENTRY;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return MASK_SAVE;
        default:                  return 32'd0;   // pgd, cpuid and holes.
    endcase
endfunction

function automatic void init_state();
    m_csr.delete();
    foreach (csr_list[i]) begin
        if (csr_list[i] != CSR_PGD && csr_list[i] != CSR_CPUID) begin
            m_csr[csr_list[i]] = 32'd0;
        end
    end
    m_csr[CSR_CRMD] = 32'h0000_0008;   // Only da set.
    exp_q.delete();
    req_cred  = CSR_REQ_DEPTH;
    cons_cred = RESP_CREDITS;
    owed      = 0;
endfunction

function automatic u32_t predict_read(csr_addr_t a);
    u32_t v;
    if (a == CSR_PGD) begin
        v = m_csr[CSR_BADV];
        v = v[31] ? m_csr[CSR_PGDH] : m_csr[CSR_PGDL];   // High half uses pgdh.
        return v & 32'hffff_f000;
    end
    if (!m_csr.exists(a)) begin
        return 32'd0;
    end
    v = m_csr[a];
    if (a == CSR_ASID) begin
        return {v[31:24], 8'd10, v[15:0]};   // Fixed ASID width field.
    end
    return v;
endfunction

function automatic u32_t predict_access(csr_addr_t a, logic w, u32_t d);
    u32_t old_val;
    u32_t mask;
    old_val = predict_read(a);
    mask    = write_mask(a);
    if (w && m_csr.exists(a)) begin
        m_csr[a] = (m_csr[a] & ~mask) | (d & mask);
    end
    return old_val;
endfunction

// Returns the redirect target of the trap.
function automatic u32_t apply_trap(ecode_t ec, u32_t pc, u32_t bv, logic bwe);
    u32_t crmd;
    crmd             = m_csr[CSR_CRMD];
    m_csr[CSR_PRMD]  = (m_csr[CSR_PRMD] & ~32'h7) | (crmd & 32'h7);   // Save plv and ie.
    m_csr[CSR_CRMD]  = crmd & ~32'h7;
    m_csr[CSR_ESTAT] = (m_csr[CSR_ESTAT] & ~32'h003f_0000) | {10'd0, ec, 16'd0};
    m_csr[CSR_ERA]   = pc;
    if (bwe) begin
        m_csr[CSR_BADV] = bv;
    end
    return m_csr[CSR_EENTRY];
endfunction

function automatic u32_t apply_ertn();
    m_csr[CSR_CRMD] = (m_csr[CSR_CRMD] & ~32'h7) | (m_csr[CSR_PRMD] & 32'h7);
    return m_csr[CSR_ERA];
endfunction

`endif

//--- testbench/tb_csr_unit.sv
`timescale 1ns/10ps

module tb_csr_unit;
    import csr_pkg::*;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      req_valid;
    csr_addr_t req_addr;
    logic      req_we;
    u32_t      req_wdata;
    logic      req_credit;
    logic      resp_valid;
    u32_t      resp_data;
    logic      resp_credit;
    logic      trap;
    ecode_t    trap_ecode;
    u32_t      trap_pc;
    u32_t      trap_badv;
    logic      trap_badv_we;
    logic      ertn;
    logic      redirect_valid;
    u32_t      redirect_pc;
    plv_t      crmd_plv;
    logic      crmd_ie;

    int    seed     = 32'hc063_413a;
    int    n_random = 200;
    int    n_fixed  = 120;   // Directed requests of all tests, rounded up.
    int    checks;
    int    errors;
    int    n_tests;
    int    test_errors_at;
    int    resp_seen;
    logic  hold_credit;      // Consumer withholds resp_credit.
    string cur_test;

    `include "csr_model.svh"

    csr_unit_top i_csr_unit_top (.*);

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(string what, u32_t exp, u32_t act);
        checks++;
        assert (act === exp) else begin
            $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // One cycle. Samples outputs at the falling edge and plays the consumer.
    task automatic step();
        u32_t exp;
        logic exp_redirect;
        exp_redirect = trap | ertn;   // Event driven in the cycle now ending.
        @(negedge clk);
        check_value("redirect_valid", 32'(exp_redirect), 32'(redirect_valid));
        if (req_credit) begin
            req_cred++;
        end
        if (resp_valid) begin
            resp_seen++;
            checks++;
            assert (cons_cred > 0) else begin
                $display("%s: response sent with no downstream credit", cur_test);
                errors++;
            end
            cons_cred--;
            owed++;
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("%s: response arrived with no request outstanding", cur_test);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                check_value("resp_data", exp, resp_data);
            end
        end
        if (resp_credit) begin
            cons_cred++;   // Taken by the egress at the edge just passed.
        end
        resp_credit = 1'b0;
        if (!hold_credit && owed > 0) begin
            resp_credit = 1'b1;
            owed--;
        end
    endtask

    task automatic drive_req(csr_addr_t a, logic w, u32_t d, u32_t exp);
        req_valid = 1'b1;
        req_addr  = a;
        req_we    = w;
        req_wdata = d;
        req_cred--;
        exp_q.push_back(exp);
    endtask

    task automatic issue_req(csr_addr_t a, logic w, u32_t d, u32_t exp);
        while (req_cred == 0) begin
            step();
        end
        drive_req(a, w, d, exp);
        step();
        req_valid = 1'b0;
    endtask

    task automatic access(csr_addr_t a, logic w, u32_t d);
        issue_req(a, w, d, predict_access(a, w, d));
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || owed != 0 || resp_credit) begin
            step();
        end
    endtask

    function automatic csr_addr_t pick_addr();
        int r;
        int idx;
        r = $random(seed);
        if (r[3:0] == 4'd0) begin
            return r[29:16];   // Mostly holes.
        end
        idx = (r >> 8) & 255;
        return csr_list[idx % 22];
    endfunction

    task automatic begin_test(string name);
        cur_test       = name;
        test_errors_at = errors;
    endtask

    task automatic end_test();
        drain();
        check_value("requester credits", CSR_REQ_DEPTH, req_cred);
        n_tests++;
        if (errors == test_errors_at) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: FAILED with %0d errors", cur_test, errors - test_errors_at);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        csr_addr_t a;
        u32_t      d;
        logic      w;
        u32_t      exp_pc;
        int        sent;
        int        resp_before;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_we       = 1'b0;
        req_wdata    = '0;
        resp_credit  = 1'b0;
        trap         = 1'b0;
        trap_ecode   = '0;
        trap_pc      = '0;
        trap_badv    = '0;
        trap_badv_we = 1'b0;
        ertn         = 1'b0;
        hold_credit  = 1'b0;
        checks       = 0;
        errors       = 0;
        n_tests      = 0;
        resp_seen    = 0;
        cur_test     = "reset";
        init_state();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset_values");
        issue_req(CSR_CRMD, 1'b0, 32'd0, 32'h0000_0008);
        issue_req(CSR_ASID, 1'b0, 32'd0, 32'h000a_0000);
        issue_req(CSR_CPUID, 1'b0, 32'd0, 32'd0);
        issue_req(14'h3ff, 1'b0, 32'd0, 32'd0);   // No CSR lives here.
        foreach (csr_list[i]) begin
            access(csr_list[i], 1'b0, 32'd0);
        end
        end_test();

        begin_test("masked_writes");
        for (int i = 0; i < n_random; i++) begin
            a = pick_addr();
            d = $random(seed);
            w = ($random(seed) & 3) != 0;
            access(a, w, d);
        end
        access(CSR_PGD, 1'b1, 32'hffff_ffff);
        access(CSR_CPUID, 1'b1, 32'hffff_ffff);
        foreach (csr_list[i]) begin
            access(csr_list[i], 1'b0, 32'd0);
        end
        end_test();

        begin_test("old_value_return");
        for (int i = 0; i < 2; i++) begin
            a = (i == 0) ? CSR_SAVE1 : CSR_ERA;
            d = $random(seed);
            access(a, 1'b1, d);              // Returns the value before the write.
            issue_req(a, 1'b0, 32'd0, d);
        end
        end_test();

        begin_test("trap_ertn");
        for (int i = 0; i < 4; i++) begin
            access(CSR_CRMD, 1'b1, $random(seed));
            access(CSR_EENTRY, 1'b1, $random(seed));
            drain();
            d            = $random(seed);
            trap         = 1'b1;
            trap_ecode   = d[5:0];
            trap_badv_we = d[8];
            trap_pc      = $random(seed);
            trap_badv    = $random(seed);
            exp_pc       = apply_trap(trap_ecode, trap_pc, trap_badv, trap_badv_we);
            step();
            trap = 1'b0;
            check_value("trap redirect_pc", exp_pc, redirect_pc);
            check_value("trap crmd_plv", 32'd0, 32'(crmd_plv));
            check_value("trap crmd_ie", 32'd0, 32'(crmd_ie));
            access(CSR_PRMD, 1'b0, 32'd0);
            access(CSR_ESTAT, 1'b0, 32'd0);
            access(CSR_ERA, 1'b0, 32'd0);
            access(CSR_BADV, 1'b0, 32'd0);
            drain();
            exp_pc = apply_ertn();
            ertn   = 1'b1;
            step();
            ertn = 1'b0;
            d    = m_csr[CSR_CRMD];
            check_value("ertn redirect_pc", exp_pc, redirect_pc);
            check_value("ertn crmd_plv", 32'(d[1:0]), 32'(crmd_plv));
            check_value("ertn crmd_ie", 32'(d[2]), 32'(crmd_ie));
        end
        end_test();

        begin_test("pgd_select");
        access(CSR_PGDL, 1'b1, $random(seed));
        access(CSR_PGDH, 1'b1, $random(seed));
        access(CSR_BADV, 1'b1, $random(seed) & 32'h7fff_ffff);
        access(CSR_PGD, 1'b0, 32'd0);
        access(CSR_BADV, 1'b1, $random(seed) | 32'h8000_0000);
        access(CSR_PGD, 1'b0, 32'd0);
        end_test();

        begin_test("back_pressure");
        drain();
        hold_credit = 1'b1;
        sent        = 0;
        resp_before = resp_seen;
        repeat (30) begin
            if (req_cred > 0 && sent < 10) begin
                a = pick_addr();
                d = $random(seed);
                drive_req(a, d[0], d, predict_access(a, d[0], d));
                sent++;
            end else begin
                req_valid = 1'b0;
            end
            step();
        end
        req_valid = 1'b0;
        check_value("accepted while held", CSR_REQ_DEPTH + RESP_CREDITS, sent);
        check_value("responses while held", RESP_CREDITS, resp_seen - resp_before);
        hold_credit = 1'b0;
        while (sent < 10) begin
            access(pick_addr(), 1'b0, 32'd0);
            sent++;
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Generous bound of 20 cycles per request.
    initial begin
        repeat ((n_random + n_fixed) * 20) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles",
                 (n_random + n_fixed) * 20);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- files.f
+incdir+testbench
hw/csr_pkg.sv
hw/csr_issue_if.sv
hw/csr_req_ingress.sv
hw/csr_regfile.sv
hw/csr_excp_seq.sv
hw/csr_resp_egress.sv
hw/csr_unit_top.sv
testbench/tb_csr_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!
SOURCES   := $(wildcard hw/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
